//--- logic/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ============================================================================
// Data cache geometry and constants.
// ============================================================================

// Number of line index bits.
// The index is taken from address bits 13 down to 2.
`define DCACHE_INDEX_BITS 12

// Addresses below this value are cached.
`define DCACHE_CACHEABLE_LIMIT 32'h4000_0000

// One entry is {data[31:0], tag[29:0], dirty, valid}.
`define DCACHE_ENTRY_WIDTH 64

// Written into every line while clearing, valid and dirty are zero.
`define DCACHE_CLEAR_WORD 64'h0000_0000_ffff_fffc

`endif

//--- logic/dcache_pkg.sv
package dcache_pkg;

	// ========================================================================
	// Controller states.
	// ========================================================================

	typedef enum logic [2:0] {
		IDLE,
		PASS,
		READ_LOOKUP,
		READ_WRITEBACK,
		READ_FILL,
		WRITE_LOOKUP,
		WRITE_WRITEBACK
	} ctrl_state_t;

	// ========================================================================
	// One cache line entry.
	// ========================================================================

	// Tag is the full word address of the cached word.
	typedef struct packed {
		logic [31:0] data;
		logic [29:0] tag;
		logic        dirty;
		logic        valid;
	} cache_entry_t;

endpackage

//--- logic/cache_line_ram.sv
`timescale 1ns/1ps

`include "dcache_consts.svh"

module cache_line_ram (
	input  logic                          i_clock,
	input  logic                          i_arst_n,

	// Controller side.
	input  logic                          i_write,
	input  logic [`DCACHE_INDEX_BITS-1:0] i_index,
	input  dcache_pkg::cache_entry_t      i_wentry,
	output dcache_pkg::cache_entry_t      o_rentry,
	output logic                          o_cleared
);

	localparam int unsigned LINES = 1 << `DCACHE_INDEX_BITS;

	logic [`DCACHE_ENTRY_WIDTH-1:0] mem [0:LINES-1];

	logic [`DCACHE_INDEX_BITS-1:0] clear_index;
	logic                          ram_write;
	logic [`DCACHE_INDEX_BITS-1:0] ram_waddr;
	logic [`DCACHE_ENTRY_WIDTH-1:0] ram_wdata;

	// ========================================================================
	// Clearing engine.
	// ========================================================================

	// One line per cycle after reset, then hand over to the controller.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			clear_index <= '0;
			o_cleared   <= 1'b0;
		end else if (!o_cleared) begin
			clear_index <= clear_index + 1'b1;
			if (&clear_index) begin
				o_cleared <= 1'b1;
			end
		end
	end

	// Controller writes are dropped until clearing is done.
	always_comb begin
		if (o_cleared) begin
			ram_write = i_write;
			ram_waddr = i_index;
			ram_wdata = i_wentry;
		end else begin
			ram_write = 1'b1;
			ram_waddr = clear_index;
			ram_wdata = `DCACHE_CLEAR_WORD;
		end
	end

	// ========================================================================
	// Storage.
	// ========================================================================

	// Read returns the old word when the same line is written.
	always_ff @(posedge i_clock) begin
		if (ram_write) begin
			mem[ram_waddr] <= ram_wdata;
		end
		o_rentry <= dcache_pkg::cache_entry_t'(mem[i_index]);
	end

	// Once the RAM is cleared it stays usable.
	cleared_sticky: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		o_cleared |=> o_cleared
	);

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_ctrl (
	input  logic                          i_clock,
	input  logic                          i_arst_n,

	// CPU port.
	input  logic                          i_cpu_request,
	input  logic                          i_cpu_rw,
	input  logic [31:0]                   i_cpu_address,
	input  logic [31:0]                   i_cpu_wdata,
	output logic                          o_cpu_ready,
	output logic [31:0]                   o_cpu_rdata,

	// Bus port.
	output logic                          o_bus_request,
	output logic                          o_bus_rw,
	output logic [31:0]                   o_bus_address,
	output logic [31:0]                   o_bus_wdata,
	input  logic                          i_bus_ready,
	input  logic [31:0]                   i_bus_rdata,

	// Line RAM.
	output logic                          o_ram_write,
	output logic [`DCACHE_INDEX_BITS-1:0] o_ram_index,
	output dcache_pkg::cache_entry_t      o_ram_wentry,
	input  dcache_pkg::cache_entry_t      i_ram_rentry,
	input  logic                          i_ram_cleared
);

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::ctrl_state_t next_state;

	logic        cacheable;
	logic        tag_match;
	logic        victim_dirty;
	logic [31:0] victim_address;

	// ========================================================================
	// Lookup.
	// ========================================================================

	assign cacheable = i_cpu_address < `DCACHE_CACHEABLE_LIMIT;

	// The RAM always looks at the line of the current CPU address.
	assign o_ram_index = i_cpu_address[`DCACHE_INDEX_BITS+1:2];

	assign tag_match      = i_ram_rentry.valid && (i_ram_rentry.tag == i_cpu_address[31:2]);
	assign victim_dirty   = i_ram_rentry.valid && i_ram_rentry.dirty;
	assign victim_address = {i_ram_rentry.tag, 2'b00};

	// ========================================================================
	// State register.
	// ========================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= dcache_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// ========================================================================
	// Next state and outputs.
	// ========================================================================

	always_comb begin
		next_state = state;

		o_cpu_ready = 1'b0;
		o_cpu_rdata = 32'h0;

		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = 32'h0;
		o_bus_wdata   = 32'h0;

		// Default entry is the CPU write, marked dirty.
		o_ram_write        = 1'b0;
		o_ram_wentry.data  = i_cpu_wdata;
		o_ram_wentry.tag   = i_cpu_address[31:2];
		o_ram_wentry.dirty = 1'b1;
		o_ram_wentry.valid = 1'b1;

		case (state)
			dcache_pkg::IDLE: begin
				if (i_cpu_request) begin
					if (i_ram_cleared && cacheable) begin
						if (i_cpu_rw) begin
							next_state = dcache_pkg::WRITE_LOOKUP;
						end else begin
							next_state = dcache_pkg::READ_LOOKUP;
						end
					end else begin
						next_state = dcache_pkg::PASS;
					end
				end
			end

			// Not cached, the bus sees the CPU access as it is.
			dcache_pkg::PASS: begin
				o_bus_request = i_cpu_request;
				o_bus_rw      = i_cpu_rw;
				o_bus_address = i_cpu_address;
				o_bus_wdata   = i_cpu_wdata;
				o_cpu_ready   = i_bus_ready;
				o_cpu_rdata   = i_bus_rdata;
				if (!i_cpu_request) begin
					next_state = dcache_pkg::IDLE;
				end
			end

			// ----------------------------------------------------------------
			// Read path.
			// ----------------------------------------------------------------

			dcache_pkg::READ_LOOKUP: begin
				o_cpu_rdata = i_ram_rentry.data;
				if (tag_match) begin
					o_cpu_ready = 1'b1;
					next_state  = dcache_pkg::IDLE;
				end else if (victim_dirty) begin
					next_state = dcache_pkg::READ_WRITEBACK;
				end else begin
					next_state = dcache_pkg::READ_FILL;
				end
			end

			// Victim goes back to memory before the fill.
			dcache_pkg::READ_WRITEBACK: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = victim_address;
				o_bus_wdata   = i_ram_rentry.data;
				if (i_bus_ready) begin
					next_state = dcache_pkg::READ_FILL;
				end
			end

			dcache_pkg::READ_FILL: begin
				o_bus_request = 1'b1;
				o_bus_address = i_cpu_address;
				o_cpu_rdata   = i_bus_rdata;
				if (i_bus_ready) begin
					// Fresh line is clean.
					o_ram_write        = 1'b1;
					o_ram_wentry.data  = i_bus_rdata;
					o_ram_wentry.dirty = 1'b0;
					o_cpu_ready        = 1'b1;
					next_state         = dcache_pkg::IDLE;
				end
			end

			// ----------------------------------------------------------------
			// Write path.
			// ----------------------------------------------------------------

			dcache_pkg::WRITE_LOOKUP: begin
				if (victim_dirty && !tag_match) begin
					next_state = dcache_pkg::WRITE_WRITEBACK;
				end else begin
					o_ram_write = 1'b1;
					o_cpu_ready = 1'b1;
					next_state  = dcache_pkg::IDLE;
				end
			end

			dcache_pkg::WRITE_WRITEBACK: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = victim_address;
				o_bus_wdata   = i_ram_rentry.data;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_cpu_ready = 1'b1;
					next_state  = dcache_pkg::IDLE;
				end
			end

			default: begin
				next_state = dcache_pkg::IDLE;
			end
		endcase
	end

	// ========================================================================
	// Checks.
	// ========================================================================

	// A stalled bus transaction keeps its address and direction.
	bus_stable: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		(o_bus_request && !i_bus_ready) |=>
			(o_bus_request && $stable(o_bus_address) && $stable(o_bus_rw))
	);

	// Cached accesses answer with a single pulse.
	ready_pulse: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		(o_cpu_ready && state != dcache_pkg::PASS) |=> !o_cpu_ready
	);

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_top (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// CPU port.
	input  logic        i_cpu_request,
	input  logic        i_cpu_rw,
	input  logic [31:0] i_cpu_address,
	input  logic [31:0] i_cpu_wdata,
	output logic        o_cpu_ready,
	output logic [31:0] o_cpu_rdata,

	// Bus port.
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	// Controller to line RAM.
	logic                          ram_write;
	logic [`DCACHE_INDEX_BITS-1:0] ram_index;
	dcache_pkg::cache_entry_t      ram_wentry;
	dcache_pkg::cache_entry_t      ram_rentry;
	logic                          ram_cleared;

	dcache_ctrl ctrl_i (
		.i_clock       (i_clock),
		.i_arst_n      (i_arst_n),
		.i_cpu_request (i_cpu_request),
		.i_cpu_rw      (i_cpu_rw),
		.i_cpu_address (i_cpu_address),
		.i_cpu_wdata   (i_cpu_wdata),
		.o_cpu_ready   (o_cpu_ready),
		.o_cpu_rdata   (o_cpu_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_ram_write   (ram_write),
		.o_ram_index   (ram_index),
		.o_ram_wentry  (ram_wentry),
		.i_ram_rentry  (ram_rentry),
		.i_ram_cleared (ram_cleared)
	);

	cache_line_ram ram_i (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_write   (ram_write),
		.i_index   (ram_index),
		.i_wentry  (ram_wentry),
		.o_rentry  (ram_rentry),
		.o_cleared (ram_cleared)
	);

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic o_clock,
	output logic o_arst_n
);

	// 40 ns period.
	initial begin
		o_clock = 1'b0;
		forever begin
			#20 o_clock = ~o_clock;
		end
	end

	// Reset held low for two cycles, released on a falling edge.
	initial begin
		o_arst_n = 1'b0;
		repeat (2) @(posedge o_clock);
		@(negedge o_clock);
		o_arst_n = 1'b1;
	end

endmodule

//--- verification/bus_memory.sv
`timescale 1ns/1ps

module bus_memory (
	input  logic        i_clock,
	input  logic        i_arst_n,
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata
);

	logic [31:0] mem [int unsigned];

	int unsigned wait_cycles;
	logic        busy;

	// Traffic log, read by the testbench.
	int unsigned write_count;
	int unsigned read_count;
	logic [31:0] last_waddr;
	logic [31:0] last_wdata;
	logic [31:0] last_raddr;

	// Unwritten words hold a value made from the whole address.
	function automatic logic [31:0] fill_value(input logic [31:0] address);
		return {address[15:0], address[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	// Responds on falling edges, so ready is stable at the rising edge.
	always @(negedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_ready     <= 1'b0;
			o_rdata     <= 32'h0;
			busy        = 1'b0;
			wait_cycles = 0;
			write_count = 0;
			read_count  = 0;
			last_waddr  = 32'h0;
			last_wdata  = 32'h0;
			last_raddr  = 32'h0;
		end else if (o_ready) begin
			o_ready <= 1'b0;
		end else if (i_request) begin
			if (!busy) begin
				busy        = 1'b1;
				wait_cycles = $urandom % 6;
			end
			if (wait_cycles == 0) begin
				busy = 1'b0;
				if (i_rw) begin
					mem[i_address] = i_wdata;
					write_count    = write_count + 1;
					last_waddr     = i_address;
					last_wdata     = i_wdata;
				end else begin
					o_rdata    <= mem.exists(i_address) ? mem[i_address] : fill_value(i_address);
					read_count = read_count + 1;
					last_raddr = i_address;
				end
				o_ready <= 1'b1;
			end else begin
				wait_cycles = wait_cycles - 1;
			end
		end
	end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

	typedef enum int {
		TR_NONE,
		TR_WRITEBACK,
		TR_FILL,
		TR_PASS
	} traffic_t;

	localparam int NUM = 18;

	logic        clock;
	logic        arst_n;
	logic        cpu_request;
	logic        cpu_rw;
	logic [31:0] cpu_address;
	logic [31:0] cpu_wdata;
	logic        cpu_ready;
	logic [31:0] cpu_rdata;
	logic        bus_request;
	logic        bus_rw;
	logic [31:0] bus_address;
	logic [31:0] bus_wdata;
	logic        bus_ready;
	logic [31:0] bus_rdata;

	int unsigned cycles;
	int          error_count;

	// ========================================================================
	// Stimulus table and reference memory.
	// ========================================================================

	logic        tbl_rw    [NUM];
	logic [31:0] tbl_addr  [NUM];
	logic [31:0] tbl_wdata [NUM];
	logic [31:0] tbl_exp   [NUM];
	traffic_t    tbl_cls   [NUM];
	logic [31:0] tbl_vaddr [NUM];
	logic [31:0] tbl_vdata [NUM];
	logic        tbl_wait  [NUM];
	int          tbl_count;

	logic [31:0] ref_mem [int unsigned];

	tb_clock clock_i (
		.o_clock  (clock),
		.o_arst_n (arst_n)
	);

	bus_memory bus_i (
		.i_clock   (clock),
		.i_arst_n  (arst_n),
		.i_request (bus_request),
		.i_rw      (bus_rw),
		.i_address (bus_address),
		.i_wdata   (bus_wdata),
		.o_ready   (bus_ready),
		.o_rdata   (bus_rdata)
	);

	dcache_top dcache_top_i (
		.i_clock       (clock),
		.i_arst_n      (arst_n),
		.i_cpu_request (cpu_request),
		.i_cpu_rw      (cpu_rw),
		.i_cpu_address (cpu_address),
		.i_cpu_wdata   (cpu_wdata),
		.o_cpu_ready   (cpu_ready),
		.o_cpu_rdata   (cpu_rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	always @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	function automatic logic [31:0] memory_pattern(input logic [31:0] address);
		return {address[15:0], address[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] address);
		return ref_mem.exists(address) ? ref_mem[address] : memory_pattern(address);
	endfunction

	// The reference memory runs while the table is built.
	task automatic add_entry(input logic rw, input logic [31:0] addr, input logic [31:0] wdata,
			input traffic_t cls, input logic [31:0] vaddr, input logic wait_clear);
		tbl_rw[tbl_count]    = rw;
		tbl_addr[tbl_count]  = addr;
		tbl_wdata[tbl_count] = wdata;
		tbl_cls[tbl_count]   = cls;
		tbl_vaddr[tbl_count] = vaddr;
		tbl_vdata[tbl_count] = ref_read(vaddr);
		tbl_wait[tbl_count]  = wait_clear;
		tbl_exp[tbl_count]   = ref_read(addr);
		if (rw) begin
			ref_mem[addr] = wdata;
		end
		tbl_count = tbl_count + 1;
	endtask

	// ========================================================================
	// Compare tasks.
	// ========================================================================

	task automatic report_failure(input string text);
		$display("%s", text);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count = error_count + 1;
			report_failure($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_traffic(input int unsigned writes, input int unsigned reads,
			input int unsigned exp_writes, input int unsigned exp_reads,
			input logic [31:0] waddr, input logic [31:0] wdata,
			input logic [31:0] exp_waddr, input logic [31:0] exp_wdata);
		if (writes != exp_writes) begin
			error_count = error_count + 1;
			report_failure($sformatf("Error at %0t: bus write count is %0d, expected %0d",
				$time, writes, exp_writes));
		end
		if (reads != exp_reads) begin
			error_count = error_count + 1;
			report_failure($sformatf("Error at %0t: bus read count is %0d, expected %0d",
				$time, reads, exp_reads));
		end
		if (exp_writes != 0) begin
			check_word("o_bus_address", waddr, exp_waddr);
			check_word("o_bus_wdata", wdata, exp_wdata);
		end
	endtask

	task automatic check_entry(input string name, input dcache_pkg::cache_entry_t got,
			input dcache_pkg::cache_entry_t exp);
		if (got !== exp) begin
			error_count = error_count + 1;
			report_failure($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	// ========================================================================
	// One access through the CPU port.
	// ========================================================================

	task automatic run_access(input int i);
		int unsigned              writes0;
		int unsigned              reads0;
		int unsigned              exp_w;
		int unsigned              exp_r;
		logic [31:0]              rdata;
		dcache_pkg::cache_entry_t got_entry;
		dcache_pkg::cache_entry_t exp_entry;

		@(negedge clock);
		writes0     = bus_i.write_count;
		reads0      = bus_i.read_count;
		cpu_request = 1'b1;
		cpu_rw      = tbl_rw[i];
		cpu_address = tbl_addr[i];
		cpu_wdata   = tbl_wdata[i];
		// Ready is looked at well before the rising edge.
		#5;
		while (!cpu_ready) begin
			@(negedge clock);
			#5;
		end
		rdata = cpu_rdata;
		@(negedge clock);
		cpu_request = 1'b0;

		if (!tbl_rw[i]) begin
			check_word("o_cpu_rdata", rdata, tbl_exp[i]);
		end

		case (tbl_cls[i])
			TR_NONE: begin
				exp_w = 0;
				exp_r = 0;
			end
			TR_FILL: begin
				exp_w = 0;
				exp_r = 1;
			end
			TR_WRITEBACK: begin
				exp_w = 1;
				exp_r = tbl_rw[i] ? 0 : 1;
			end
			default: begin
				exp_w = tbl_rw[i] ? 1 : 0;
				exp_r = tbl_rw[i] ? 0 : 1;
			end
		endcase

		check_traffic(bus_i.write_count - writes0, bus_i.read_count - reads0, exp_w, exp_r,
			bus_i.last_waddr, bus_i.last_wdata,
			(tbl_cls[i] == TR_WRITEBACK) ? tbl_vaddr[i] : tbl_addr[i],
			(tbl_cls[i] == TR_WRITEBACK) ? tbl_vdata[i] : tbl_wdata[i]);

		if (exp_r != 0) begin
			check_word("bus read address", bus_i.last_raddr, tbl_addr[i]);
		end

		// The evicted word, seen as the entry it came from.
		if (tbl_cls[i] == TR_WRITEBACK) begin
			got_entry = '{data: bus_i.last_wdata, tag: bus_i.last_waddr[31:2], dirty: 1'b1,
				valid: 1'b1};
			exp_entry = '{data: tbl_vdata[i], tag: tbl_vaddr[i][31:2], dirty: 1'b1,
				valid: 1'b1};
			check_entry("evicted entry", got_entry, exp_entry);
		end
	endtask

	// ========================================================================
	// Main sequence.
	// ========================================================================

	initial begin
		void'($urandom(32'h404b));
		cpu_request = 1'b0;
		cpu_rw      = 1'b0;
		cpu_address = 32'h0;
		cpu_wdata   = 32'h0;
		error_count = 0;
		tbl_count   = 0;

		// Pass-through while the RAM is clearing.
		add_entry(1'b1, 32'h0000_0100, 32'h1111_0001, TR_PASS, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_0100, 32'h0, TR_PASS, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_0200, 32'h0, TR_PASS, 32'h0, 1'b0);
		// Hits, fills and evictions. A, B and C share one index.
		add_entry(1'b1, 32'h0000_0300, 32'h2222_0003, TR_NONE, 32'h0, 1'b1);
		add_entry(1'b0, 32'h0000_0300, 32'h0, TR_NONE, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_0400, 32'h0, TR_FILL, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_0400, 32'h0, TR_NONE, 32'h0, 1'b0);
		add_entry(1'b1, 32'h0000_1000, 32'h3333_000a, TR_NONE, 32'h0, 1'b0);
		add_entry(1'b1, 32'h0000_5000, 32'h4444_000b, TR_WRITEBACK, 32'h0000_1000, 1'b0);
		add_entry(1'b0, 32'h0000_1000, 32'h0, TR_WRITEBACK, 32'h0000_5000, 1'b0);
		add_entry(1'b1, 32'h0000_1000, 32'h5555_000a, TR_NONE, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0001_1000, 32'h0, TR_WRITEBACK, 32'h0000_1000, 1'b0);
		// Uncacheable region, on the same line index as the cached word.
		add_entry(1'b0, 32'h8000_1000, 32'h0, TR_PASS, 32'h0, 1'b0);
		add_entry(1'b1, 32'h4000_1000, 32'h6666_0020, TR_PASS, 32'h0, 1'b0);
		add_entry(1'b0, 32'h4000_1000, 32'h0, TR_PASS, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0001_1000, 32'h0, TR_NONE, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_5000, 32'h0, TR_FILL, 32'h0, 1'b0);
		add_entry(1'b0, 32'h0000_0100, 32'h0, TR_FILL, 32'h0, 1'b0);

		@(posedge arst_n);
		for (int i = 0; i < tbl_count; i++) begin
			if (tbl_wait[i]) begin
				while (cycles < 4100) begin
					@(negedge clock);
				end
			end
			run_access(i);
		end

		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Clearing time plus a generous budget per access.
	initial begin
		#((4096 + 50 * NUM) * 40);
		report_failure("Timeout: the cache did not finish the accesses in time");
	end

endmodule

//--- vlog.f
+incdir+logic
logic/dcache_pkg.sv
logic/cache_line_ram.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verification/tb_clock.sv
verification/bus_memory.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/dcache_pkg.sv
      - logic/cache_line_ram.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clock.sv
      - verification/bus_memory.sv
      - verification/dcache_tb.sv
